/* Makefile */
# Verilator build and regression run for the DCCM

VERILATOR ?= verilator
TOP       ?= dccm_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard design/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
design/mem_cfg_pkg.sv
design/ecc_pkg.sv
design/dccm_bank_if.sv
design/dccm_ram.sv
design/dccm_bank.sv
design/dccm_ctrl.sv
design/dccm_top.sv
verif/dccm_props.sv
verif/dccm_tb.sv

/* design/dccm_bank.sv */
/* DCCM ECC bank
   Stores SECDED-encoded words and corrects single-bit errors on the read path */
module dccm_bank import mem_cfg_pkg::*, ecc_pkg::*; (
   input logic     CLK,
   dccm_bank_if.bank bus
);

   code_t     wr_code;
   code_t     ram_q;
   syndrome_t syn;
   logic      syn_parity;
   logic      syn_hamming;
   data_t     corr_mask;

   // Data bit that lives at a given Hamming position, as a one-hot mask.
   // Positions of check bits, or past the end of the word, give no data flip
   function automatic data_t flip_mask(logic [ECC_W-2:0] syn_pos);
      data_t mask;
      int di;
      mask = '0;
      di = 0;
      for (int unsigned pos = 1; pos < CODE_W; pos++) begin
         if ((pos & (pos - 1)) != 0) begin
            if (pos == 32'(syn_pos)) begin
               mask[di] = 1'b1;
            end
            di++;
         end
      end
      return mask;
   endfunction

   // The inject mask lets a test plant faults in any codeword bit
   assign wr_code = {ecc_encode(bus.wdata), bus.wdata} ^ bus.inject;

   dccm_ram #(
      .depth (BANK_DEPTH),
      .width (CODE_W)
   ) ram_i (
      .CLK (CLK),
      .ME  (bus.me),
      .WE  (bus.we),
      .ADR (bus.addr),
      .D   (wr_code),
      .Q   (ram_q)
   );

   // Read check works straight off the RAM output register
   assign syn = ecc_syndrome(ram_q);
   assign syn_parity = syn[ECC_W-1];
   assign syn_hamming = |syn[ECC_W-2:0];

   // An odd number of flips shows as a parity mismatch, treated as one error
   assign corr_mask = syn_parity ? flip_mask(syn[ECC_W-2:0]) : '0;

   // A double error passes the stored data bits through untouched
   assign bus.rd_data = ram_q[DATA_W-1:0] ^ corr_mask;
   assign bus.single_err = syn_parity;
   assign bus.double_err = !syn_parity && syn_hamming;

endmodule

/* design/dccm_bank_if.sv */
/* Controller to bank link
   Carries one bank request and the checked read result coming back */
interface dccm_bank_if import mem_cfg_pkg::*, ecc_pkg::*; ();

   // Request side
   logic       me;
   logic       we;
   bank_addr_t addr;
   data_t      wdata;
   code_t      inject;

   // Read result, meaningful in the cycle after a read was sampled
   data_t      rd_data;
   logic       single_err;
   logic       double_err;

   modport ctrl (
      output me, we, addr, wdata, inject,
      input  rd_data, single_err, double_err
   );

   modport bank (
      input  me, we, addr, wdata, inject,
      output rd_data, single_err, double_err
   );

endinterface

/* design/dccm_ctrl.sv */
/* DCCM controller
   Steers requests to the interleaved banks and registers the selected read result */
module dccm_ctrl import mem_cfg_pkg::*, ecc_pkg::*; (
   input  logic     CLK,
   input  logic     rst,
   input  logic     req,
   input  logic     we,
   input  addr_t    addr,
   input  data_t    wdata,
   input  code_t    inject,
   dccm_bank_if.ctrl bank0,
   dccm_bank_if.ctrl bank1,
   output logic     rd_valid,
   output data_t    rd_data,
   output logic     single_err,
   output logic     double_err,
   output addr_t    err_addr
);

   logic       bank_sel;
   bank_addr_t bank_addr;
   logic       rd_pend;
   addr_t      addr_q;
   data_t      pick_data;
   logic       pick_single;
   logic       pick_double;

   // Even words live in bank 0, odd words in bank 1
   assign bank_sel = addr[0];
   assign bank_addr = addr[ADDR_W-1:1];

   // Only the addressed bank is enabled, the rest of the request is shared
   assign bank0.me = req && !bank_sel;
   assign bank0.we = we;
   assign bank0.addr = bank_addr;
   assign bank0.wdata = wdata;
   assign bank0.inject = inject;

   assign bank1.me = req && bank_sel;
   assign bank1.we = we;
   assign bank1.addr = bank_addr;
   assign bank1.wdata = wdata;
   assign bank1.inject = inject;

   // One stage that follows a read while the bank output register fills
   always_ff @(posedge CLK) begin
      if (rst) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= req && !we;
      end
   end

   always_ff @(posedge CLK) begin
      addr_q <= addr;
   end

   // Bit 0 of the held address names the bank that answers
   assign pick_data = addr_q[0] ? bank1.rd_data : bank0.rd_data;
   assign pick_single = addr_q[0] ? bank1.single_err : bank0.single_err;
   assign pick_double = addr_q[0] ? bank1.double_err : bank0.double_err;

   // Flags are qualified so stale bank results never leak out
   always_ff @(posedge CLK) begin
      if (rst) begin
         rd_valid <= 1'b0;
         single_err <= 1'b0;
         double_err <= 1'b0;
         err_addr <= '0;
      end else begin
         rd_valid <= rd_pend;
         single_err <= rd_pend && pick_single;
         double_err <= rd_pend && pick_double;
         if (rd_pend && (pick_single || pick_double)) begin
            err_addr <= addr_q;
         end
      end
   end

   always_ff @(posedge CLK) begin
      rd_data <= pick_data;
   end

endmodule

/* design/dccm_ram.sv */
/* Generic synchronous single-port RAM
   Chip enable gates both access kinds, and the read word is held in an output register */
module dccm_ram #(
   parameter int depth = 512,
   parameter int width = 39
) (
   input  logic                     CLK,
   input  logic                     ME,
   input  logic                     WE,
   input  logic [$clog2(depth)-1:0] ADR,
   input  logic [width-1:0]         D,
   output logic [width-1:0]         Q
);

   logic [width-1:0] ram_core [depth];

   // A write leaves Q alone, so the last read word stays visible
   always_ff @(posedge CLK) begin
      if (ME && WE) begin
         ram_core[ADR] <= D;
      end
      if (ME && !WE) begin
         Q <= ram_core[ADR];
      end
   end

endmodule

/* design/dccm_top.sv */
/* DCCM top level
   Two word-interleaved ECC banks behind one controller, with plain request ports */
module dccm_top import mem_cfg_pkg::*, ecc_pkg::*; (
   input  logic  CLK,
   input  logic  rst,
   input  logic  req,
   input  logic  we,
   input  addr_t addr,
   input  data_t wdata,
   input  code_t inject,
   output logic  rd_valid,
   output data_t rd_data,
   output logic  single_err,
   output logic  double_err,
   output addr_t err_addr
);

   // One link per bank
   dccm_bank_if bank0_if ();
   dccm_bank_if bank1_if ();

   dccm_bank bank0_i (
      .CLK (CLK),
      .bus (bank0_if.bank)
   );

   dccm_bank bank1_i (
      .CLK (CLK),
      .bus (bank1_if.bank)
   );

   dccm_ctrl ctrl_i (
      .CLK        (CLK),
      .rst        (rst),
      .req        (req),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .inject     (inject),
      .bank0      (bank0_if.ctrl),
      .bank1      (bank1_if.ctrl),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .single_err (single_err),
      .double_err (double_err),
      .err_addr   (err_addr)
   );

endmodule

/* design/ecc_pkg.sv */
/* SECDED ECC definitions
   Codeword types plus the check-bit encoder and the syndrome builder */
package ecc_pkg;

   localparam int DATA_W = 32;

   // Six Hamming bits and one overall parity bit
   localparam int ECC_W = 7;
   localparam int CODE_W = DATA_W + ECC_W;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ECC_W-1:0] ecc_t;

   // Data in bits 31:0, Hamming bits in 37:32, overall parity in bit 38
   typedef logic [CODE_W-1:0] code_t;

   // Bits 5:0 hold the Hamming syndrome, bit 6 the overall parity mismatch
   typedef logic [ECC_W-1:0] syndrome_t;

   // Data bits take the Hamming positions 1..38 that are not powers of two,
   // in ascending order, so data bit 0 sits at position 3
   function automatic ecc_t ecc_encode(data_t data);
      ecc_t ecc;
      int di;
      ecc = '0;
      di = 0;
      for (int unsigned pos = 1; pos < CODE_W; pos++) begin
         if ((pos & (pos - 1)) != 0) begin
            // Each check bit covers the positions that have its index bit set
            for (int k = 0; k < ECC_W - 1; k++) begin
               if (pos[k]) begin
                  ecc[k] = ecc[k] ^ data[di];
               end
            end
            di++;
         end
      end
      // Overall parity makes the XOR of the whole codeword zero
      ecc[ECC_W-1] = ^{ecc[ECC_W-2:0], data};
      return ecc;
   endfunction

   // A clean codeword gives an all-zero syndrome
   function automatic syndrome_t ecc_syndrome(code_t code);
      ecc_t chk;
      syndrome_t syn;
      chk = ecc_encode(code[DATA_W-1:0]);
      syn[ECC_W-2:0] = chk[ECC_W-2:0] ^ code[CODE_W-2:DATA_W];
      syn[ECC_W-1] = ^code;
      return syn;
   endfunction

endpackage

/* design/mem_cfg_pkg.sv */
/* DCCM memory configuration
   Word geometry of the two-bank data memory and its address types */
package mem_cfg_pkg;

   // Total words in the DCCM
   localparam int DCCM_DEPTH = 1024;

   // Words are interleaved over the banks by the low address bit
   localparam int NUM_BANKS = 2;
   localparam int BANK_DEPTH = DCCM_DEPTH / NUM_BANKS;

   localparam int ADDR_W = $clog2(DCCM_DEPTH);
   localparam int BANK_ADDR_W = $clog2(BANK_DEPTH);

   // Word address, bit 0 picks the bank
   typedef logic [ADDR_W-1:0] addr_t;

   // Word address inside one bank
   typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

/* verif/dccm_props.sv */
/* DCCM timing and flag checks
   Read latency, flag exclusivity and error address tracking at the top level */
module dccm_props import mem_cfg_pkg::*; (
   input logic  CLK,
   input logic  rst,
   input logic  req,
   input logic  we,
   input addr_t addr,
   input logic  rd_valid,
   input logic  single_err,
   input logic  double_err,
   input addr_t err_addr
);

   // Failure count per assertion, summed into one total
   int unsigned lat_fails = 0;
   int unsigned both_fails = 0;
   int unsigned flag_fails = 0;
   int unsigned addr_fails = 0;
   int unsigned hold_fails = 0;
   int unsigned fail_cnt;
   logic        any_err;

   assign fail_cnt = lat_fails + both_fails + flag_fails + addr_fails + hold_fails;
   assign any_err = single_err || double_err;

   // A read sampled at one edge shows rd_valid at the second sampling edge after it
   a_rd_latency: assert property (@(posedge CLK) disable iff (rst)
      rd_valid == $past(req && !we, 2))
   else begin
      $error("rd_valid does not follow a sampled read by exactly one cycle");
      lat_fails++;
   end

   a_flags_exclusive: assert property (@(posedge CLK) disable iff (rst)
      !(single_err && double_err))
   else begin
      $error("single_err and double_err are high together");
      both_fails++;
   end

   a_flag_needs_valid: assert property (@(posedge CLK) disable iff (rst)
      any_err |-> rd_valid)
   else begin
      $error("an error flag is high without rd_valid");
      flag_fails++;
   end

   // The logged address is the one sampled with the failing read
   a_err_addr: assert property (@(posedge CLK) disable iff (rst)
      any_err |-> err_addr == $past(addr, 2))
   else begin
      $error("err_addr does not match the address of the failing read");
      addr_fails++;
   end

   a_err_addr_hold: assert property (@(posedge CLK) disable iff (rst)
      !any_err |-> $stable(err_addr))
   else begin
      $error("err_addr changed without an erroring read");
      hold_fails++;
   end

endmodule

bind dccm_top dccm_props props_i (
   .CLK        (CLK),
   .rst        (rst),
   .req        (req),
   .we         (we),
   .addr       (addr),
   .rd_valid   (rd_valid),
   .single_err (single_err),
   .double_err (double_err),
   .err_addr   (err_addr)
);

/* verif/dccm_tb.sv */
/* DCCM testbench
   Shadow memory read checks, with ECC faults planted through the inject mask */
module dccm_tb import mem_cfg_pkg::*, ecc_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 4;
   localparam int N_ALT = 64;
   localparam int N_SINGLE = 8;
   localparam int N_DOUBLE = 8;
   localparam int N_IDLE = 16;
   // Every request occupies one cycle
   localparam int N_REQ = 2 * DCCM_DEPTH + N_ALT + 2 * N_SINGLE + 4 * N_DOUBLE;
   localparam int N_READS = DCCM_DEPTH + N_ALT + N_SINGLE + 2 * N_DOUBLE;
   localparam int MARGIN = 100;
   localparam int TIMEOUT = (RESET_CYCLES + N_REQ + N_IDLE + MARGIN) * CLK_PERIOD;
   localparam logic [31:0] SEED = 32'hcc27_635b;

   typedef struct packed {
      addr_t addr;
      data_t data;
      logic  sec;
      logic  ded;
   } exp_rd_t;

   logic  CLK;
   logic  rst;
   logic  req;
   logic  we;
   addr_t addr;
   data_t wdata;
   code_t inject;
   logic  rd_valid;
   data_t rd_data;
   logic  single_err;
   logic  double_err;
   addr_t err_addr;

   data_t   shadow_data [DCCM_DEPTH];
   code_t   shadow_mask [DCCM_DEPTH];
   exp_rd_t exp_q [$];
   addr_t   exp_err_addr = '0;
   logic    in_reset;
   int      err_cnt = 0;
   int      rd_cnt = 0;

   dccm_top dut_i (
      .CLK        (CLK),
      .rst        (rst),
      .req        (req),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .inject     (inject),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .single_err (single_err),
      .double_err (double_err),
      .err_addr   (err_addr)
   );

   initial begin
      CLK = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) CLK = ~CLK;
      end
   end

   // Expected result from the written word and the number of flipped codeword bits
   function automatic exp_rd_t predict_read(addr_t a);
      exp_rd_t e;
      int flips;
      flips = $countones(shadow_mask[a]);
      e.addr = a;
      e.data = shadow_data[a];
      e.sec = (flips == 1);
      e.ded = (flips == 2);
      // Two flips cannot be located, so the data bits come back as stored
      if (flips == 2) begin
         e.data = shadow_data[a] ^ shadow_mask[a][DATA_W-1:0];
      end
      return e;
   endfunction

   function automatic int report_mismatch(string name, logic [31:0] got, logic [31:0] want);
      if (got !== want) begin
         $display("Fail %s: got %0h, expected %0h at time %0t", name, got, want, $time);
         return 1;
      end
      return 0;
   endfunction

   task automatic write_word(addr_t a, data_t d, code_t mask);
      @(negedge CLK);
      req = 1'b1;
      we = 1'b1;
      addr = a;
      wdata = d;
      inject = mask;
      shadow_data[a] = d;
      shadow_mask[a] = mask;
   endtask

   task automatic read_word(addr_t a);
      @(negedge CLK);
      req = 1'b1;
      we = 1'b0;
      addr = a;
      wdata = '0;
      inject = '0;
      exp_q.push_back(predict_read(a));
   endtask

   task automatic idle_cycles(int n);
      repeat (n) begin
         @(negedge CLK);
         req = 1'b0;
         we = 1'b0;
         inject = '0;
      end
   endtask

   always @(posedge CLK) begin
      in_reset <= rst;
   end

   // Result checks, once per cycle on the falling edge
   always @(negedge CLK) begin
      exp_rd_t e;
      if (in_reset === 1'b0) begin
         if (rd_valid) begin
            rd_cnt++;
            if (exp_q.size() == 0) begin
               $display("Unexpected rd_valid with no read outstanding at time %0t", $time);
               err_cnt++;
            end else begin
               e = exp_q.pop_front();
               err_cnt += report_mismatch("rd_data", rd_data, e.data);
               err_cnt += report_mismatch("single_err", 32'(single_err), 32'(e.sec));
               err_cnt += report_mismatch("double_err", 32'(double_err), 32'(e.ded));
               if (e.sec || e.ded) begin
                  exp_err_addr = e.addr;
               end
            end
         end else if (single_err || double_err) begin
            $display("Error flag raised without rd_valid at time %0t", $time);
            err_cnt++;
         end
         err_cnt += report_mismatch("err_addr", 32'(err_addr), 32'(exp_err_addr));
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
      $display("Regression failed");
      $finish;
   end

   initial begin
      addr_t order [DCCM_DEPTH];
      addr_t tmp;
      addr_t a;
      int j;
      int b0;
      int b1;
      int end_errs;
      end_errs = 0;
      void'($urandom(SEED));
      rst = 1'b1;
      req = 1'b0;
      we = 1'b0;
      addr = '0;
      wdata = '0;
      inject = '0;
      repeat (RESET_CYCLES) @(negedge CLK);
      rst = 1'b0;

      // Nothing may come out while the bus is quiet
      idle_cycles(8);

      // Clean fill of the whole memory, then every word read back in random order
      for (int i = 0; i < DCCM_DEPTH; i++) begin
         write_word(addr_t'(i), $urandom(), '0);
      end
      for (int i = 0; i < DCCM_DEPTH; i++) begin
         order[i] = addr_t'(i);
      end
      for (int i = DCCM_DEPTH - 1; i > 0; i--) begin
         j = int'($urandom_range(i, 0));
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < DCCM_DEPTH; i++) begin
         read_word(order[i]);
      end

      // Consecutive addresses alternate between the banks
      a = addr_t'($urandom_range(DCCM_DEPTH - N_ALT - 1, 0));
      for (int i = 0; i < N_ALT; i++) begin
         read_word(a + addr_t'(i));
      end

      for (int i = 0; i < N_SINGLE; i++) begin
         a = addr_t'($urandom_range(DCCM_DEPTH - 1, 0));
         b0 = int'($urandom_range(CODE_W - 1, 0));
         write_word(a, $urandom(), code_t'(1) << b0);
         read_word(a);
      end

      for (int i = 0; i < N_DOUBLE; i++) begin
         a = addr_t'($urandom_range(DCCM_DEPTH - 1, 0));
         b0 = int'($urandom_range(CODE_W - 1, 0));
         b1 = (b0 + 1 + int'($urandom_range(CODE_W - 2, 0))) % CODE_W;
         write_word(a, $urandom(), (code_t'(1) << b0) | (code_t'(1) << b1));
         // The clean neighbour in the other bank must leave err_addr where it is
         write_word(a ^ addr_t'(1), $urandom(), '0);
         read_word(a);
         read_word(a ^ addr_t'(1));
      end

      idle_cycles(1);
      while (exp_q.size() != 0) begin
         @(negedge CLK);
      end
      idle_cycles(4);

      if (rd_cnt != N_READS) begin
         $display("Read count mismatch: %0d results for %0d reads", rd_cnt, N_READS);
         end_errs++;
      end
      $display("Errors: %0d result checks, %0d end checks, %0d assertions",
               err_cnt, end_errs, dut_i.props_i.fail_cnt);
      if (err_cnt + end_errs + int'(dut_i.props_i.fail_cnt) == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
